// File: hdl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath widths
`define LSU_XLEN        32
`define LSU_NUM_LANES   4
`define LSU_PAGE_BITS   12
`define LSU_ASID_BITS   8
`define LSU_OFFSET_BITS 16  // immediate offset from decode
`define LSU_REG_BITS    5   // gpr index

// kseg0/kseg1 window, top two bits of the vaddr
`define LSU_UNMAPPED_SEG 2'b10
// kseg1 only, top three bits
`define LSU_UNCACHED_SEG 3'b101

// vaddr bit that picks the even/odd page of a tlb pair
`define LSU_ODD_PAGE_BIT `LSU_PAGE_BITS

`endif

// File: hdl/mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

    // load/store kinds as they arrive from decode
    typedef enum logic [3:0] {
        acc_lb  = 4'd0,
        acc_lbu = 4'd1,
        acc_lh  = 4'd2,
        acc_lhu = 4'd3,
        acc_lw  = 4'd4,
        acc_lwl = 4'd5,
        acc_lwr = 4'd6,
        acc_sb  = 4'd7,
        acc_sh  = 4'd8,
        acc_sw  = 4'd9,
        acc_swl = 4'd10,
        acc_swr = 4'd11
    } access_kind_t;

    // cp0 cause.exccode values raised here
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5
    } exc_code_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } acc_size_t;

    function automatic logic is_store_kind(input access_kind_t kind);
        return (kind >= acc_sb) && (kind <= acc_swr);
    endfunction

    // spare codes 12..15 are neither load nor store
    function automatic logic is_mem_kind(input access_kind_t kind);
        return kind <= acc_swr;
    endfunction

endpackage

`default_nettype wire

// File: hdl/mmu_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package mmu_pkg;

    // one vpn2 covers an even/odd page pair
    typedef logic [`LSU_XLEN-`LSU_PAGE_BITS-2:0] vpn2_t;
    typedef logic [`LSU_XLEN-`LSU_PAGE_BITS-1:0] pfn_t;
    typedef logic [`LSU_ASID_BITS-1:0]           asid_t;
    typedef logic [`LSU_XLEN-1:0]                paddr_t;

    // what the tlb search port returns for the selected page
    typedef struct packed {
        logic found;
        pfn_t pfn;
        logic v;
        logic d;    // writable
    } tlb_answer_t;

endpackage

`default_nettype wire

// File: hdl/ex_ifs.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

// store lane formatting results
interface lane_fmt_if
    import mem_access_pkg::*;
();
    logic [`LSU_NUM_LANES-1:0] wstrb;
    acc_size_t                 size;
    logic [`LSU_XLEN-1:0]      wdata;
    logic                      misaligned;

    modport source (output wstrb, output size, output wdata, output misaligned);
    modport sink   (input wstrb, input size, input wdata, input misaligned);
endinterface

// translation result plus tlb fault flags
interface xlate_if
    import mmu_pkg::*;
();
    paddr_t paddr;
    logic   uncache;
    logic   mapped;
    logic   tlb_miss;
    logic   tlb_invalid;
    logic   tlb_dirty_fault;

    modport source (output paddr, output uncache, output mapped,
                    output tlb_miss, output tlb_invalid, output tlb_dirty_fault);
    modport sink   (input paddr, input uncache, input mapped,
                    input tlb_miss, input tlb_invalid, input tlb_dirty_fault);
endinterface

`default_nettype wire

// File: hdl/byte_lane_formatter.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module byte_lane_formatter
    import mem_access_pkg::*;
(
    input  access_kind_t         kind,
    input  logic [1:0]           byte_offset,
    input  logic [`LSU_XLEN-1:0] store_data,
    lane_fmt_if.source           fmt
);

    logic [`LSU_NUM_LANES-1:0] strb;
    acc_size_t                 sz;
    logic [`LSU_XLEN-1:0]      data;
    logic                      misal;
    acc_size_t                 left_size;   // lwl/swl
    acc_size_t                 right_size;  // lwr/swr
    logic [4:0]                shift_up;
    logic [4:0]                shift_down;

    assign shift_up   = {byte_offset, 3'b000};
    assign shift_down = {~byte_offset, 3'b000}; // 3 - offset bytes

    assign left_size  = byte_offset[1] ? size_word :
                        (byte_offset[0] ? size_half : size_byte);
    assign right_size = !byte_offset[1] ? size_word :
                        (byte_offset[0] ? size_byte : size_half);

    always_comb begin
        strb  = '0;            // loads never write
        sz    = size_byte;
        data  = store_data;
        misal = 1'b0;
        case (kind)
            acc_lb, acc_lbu: sz = size_byte;
            acc_sb: begin
                strb = {{(`LSU_NUM_LANES-1){1'b0}}, 1'b1} << byte_offset;
                data = {4{store_data[7:0]}};
            end
            acc_lh, acc_lhu: begin
                sz    = size_half;
                misal = byte_offset[0];
            end
            acc_sh: begin
                strb  = byte_offset[1] ? 4'b1100 : 4'b0011;
                data  = {2{store_data[15:0]}};
                sz    = size_half;
                misal = byte_offset[0];
            end
            acc_lw: begin
                sz    = size_word;
                misal = |byte_offset;
            end
            acc_sw: begin
                strb  = {`LSU_NUM_LANES{1'b1}};
                sz    = size_word;
                misal = |byte_offset;
            end
            acc_lwl: sz = left_size;
            acc_swl: begin
                strb = {`LSU_NUM_LANES{1'b1}} >> ~byte_offset;
                data = store_data >> shift_down;  // msb bytes to the low lanes
                sz   = left_size;
            end
            acc_lwr: sz = right_size;
            acc_swr: begin
                strb = {`LSU_NUM_LANES{1'b1}} << byte_offset;
                data = store_data << shift_up;
                sz   = right_size;
            end
            default: ;
        endcase
    end

    assign fmt.wstrb      = strb;
    assign fmt.size       = sz;
    assign fmt.wdata      = data;
    assign fmt.misaligned = misal;

endmodule

`default_nettype wire

// File: hdl/addr_translator.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module addr_translator
    import mmu_pkg::*;
(
    input  logic [`LSU_XLEN-1:0] vaddr,
    input  logic                 is_store,
    input  logic                 is_mem,
    input  asid_t                asid,
    output vpn2_t                tlb_vpn2,
    output logic                 tlb_odd_page,
    output asid_t                tlb_asid,
    input  tlb_answer_t          tlb_ans,
    xlate_if.source              xl
);

    logic unmapped;
    logic mapped_mem;

    // kseg0/kseg1 bypass the tlb
    assign unmapped   = vaddr[`LSU_XLEN-1 -: 2] == `LSU_UNMAPPED_SEG;
    assign mapped_mem = !unmapped && is_mem;

    // search port is driven every cycle, the answer is only used when mapped
    assign tlb_vpn2     = vaddr[`LSU_XLEN-1:`LSU_ODD_PAGE_BIT+1];
    assign tlb_odd_page = vaddr[`LSU_ODD_PAGE_BIT];
    assign tlb_asid     = asid;

    assign xl.mapped  = !unmapped;
    assign xl.uncache = vaddr[`LSU_XLEN-1 -: 3] == `LSU_UNCACHED_SEG;

    always_comb begin
        if (unmapped) begin
            xl.paddr = {3'b000, vaddr[`LSU_XLEN-4:0]};
        end else begin
            xl.paddr = {tlb_ans.pfn, vaddr[`LSU_PAGE_BITS-1:0]};
        end
    end

    assign xl.tlb_miss    = mapped_mem && !tlb_ans.found;
    assign xl.tlb_invalid = mapped_mem && tlb_ans.found && !tlb_ans.v;
    // store to a clean page
    assign xl.tlb_dirty_fault = mapped_mem && is_store && tlb_ans.found
                                && tlb_ans.v && !tlb_ans.d;

endmodule

`default_nettype wire

// File: hdl/mem_req_issue.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module mem_req_issue
    import mem_access_pkg::*;
    import mmu_pkg::*;
(
    input  logic                      valid,
    input  logic                      mem_allowin,
    input  logic                      is_store,
    input  logic                      is_mem,
    input  logic [`LSU_XLEN-1:0]      vaddr,
    lane_fmt_if.sink                  fmt,
    xlate_if.sink                     xl,
    output logic                      dcache_valid,
    output logic                      dcache_op,
    output logic                      dcache_uncache,
    output paddr_t                    dcache_paddr,
    output acc_size_t                 dcache_size,
    output logic [`LSU_NUM_LANES-1:0] dcache_wstrb,
    output logic [`LSU_XLEN-1:0]      dcache_wdata,
    input  logic                      dcache_addr_ok,
    output logic                      ready,
    output logic                      has_exc,
    output exc_code_t                 exc_code,
    output logic [`LSU_XLEN-1:0]      badvaddr,
    output logic                      tlb_refill
);

    logic addr_err;
    logic tlb_fault;    // refill or invalid
    logic need_req;

    assign addr_err  = is_mem && fmt.misaligned;
    assign tlb_fault = xl.mapped && (xl.tlb_miss || xl.tlb_invalid);
    assign has_exc   = addr_err || tlb_fault || xl.tlb_dirty_fault;

    // address error wins, then tlb store/load, then modified
    always_comb begin
        if (addr_err) begin
            exc_code = is_store ? exc_ades : exc_adel;
        end else if (tlb_fault) begin
            exc_code = is_store ? exc_tlbs : exc_tlbl;
        end else if (xl.tlb_dirty_fault) begin
            exc_code = exc_mod;
        end else begin
            exc_code = exc_none;
        end
    end

    assign badvaddr   = vaddr;
    assign tlb_refill = xl.tlb_miss;    // refill vector instead of general one

    // a clean memory access has to win a cache slot before it can leave
    assign need_req     = valid && is_mem && !has_exc;
    assign dcache_valid = need_req && mem_allowin;

    // request fields depend only on the held payload, so they stay put while waiting
    assign dcache_op      = is_store;
    assign dcache_uncache = xl.uncache;
    assign dcache_paddr   = xl.paddr;
    assign dcache_size    = fmt.size;
    assign dcache_wstrb   = fmt.wstrb;
    assign dcache_wdata   = fmt.wdata;

    assign ready = !need_req || (dcache_valid && dcache_addr_ok);

endmodule

`default_nettype wire

// File: hdl/ex_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module ex_mem_stage
    import mem_access_pkg::*;
    import mmu_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    // decode side
    input  logic                        in_valid,
    output logic                        in_allowin,
    input  access_kind_t                in_kind,
    input  logic [`LSU_XLEN-1:0]        in_base,
    input  logic [`LSU_OFFSET_BITS-1:0] in_offset,
    input  logic [`LSU_XLEN-1:0]        in_store_data,
    input  logic [`LSU_REG_BITS-1:0]    in_dest,
    input  logic [`LSU_XLEN-1:0]        in_pc,
    // memory stage side
    input  logic                        mem_allowin,
    output logic                        mem_valid,
    output access_kind_t                mem_kind,
    output logic [`LSU_REG_BITS-1:0]    mem_dest,
    output logic [`LSU_XLEN-1:0]        mem_pc,
    output logic [1:0]                  mem_byte_offset,
    output logic                        mem_has_exc,
    output exc_code_t                   mem_exc_code,
    output logic [`LSU_XLEN-1:0]        mem_badvaddr,
    output logic                        mem_tlb_refill,
    // data cache
    output logic                        dcache_valid,
    output logic                        dcache_op,
    output logic                        dcache_uncache,
    output paddr_t                      dcache_paddr,
    output acc_size_t                   dcache_size,
    output logic [`LSU_NUM_LANES-1:0]   dcache_wstrb,
    output logic [`LSU_XLEN-1:0]        dcache_wdata,
    input  logic                        dcache_addr_ok,
    // tlb search port
    output vpn2_t                       tlb_vpn2,
    output logic                        tlb_odd_page,
    output asid_t                       tlb_asid,
    input  logic                        tlb_found,
    input  pfn_t                        tlb_pfn,
    input  logic                        tlb_v,
    input  logic                        tlb_d,
    // control
    input  asid_t                       asid,
    input  logic                        ex_flush
);

    logic                        stage_valid;
    logic                        exc_pending;   // set once an exception left, until flush
    access_kind_t                kind_r;
    logic [`LSU_XLEN-1:0]        base_r;
    logic [`LSU_OFFSET_BITS-1:0] offset_r;
    logic [`LSU_XLEN-1:0]        store_data_r;
    logic [`LSU_REG_BITS-1:0]    dest_r;
    logic [`LSU_XLEN-1:0]        pc_r;

    logic [`LSU_XLEN-1:0] addr_sum;
    logic [`LSU_XLEN-1:0] vaddr;
    logic                 is_store;
    logic                 is_mem;
    logic                 ready;
    logic                 has_exc;
    logic                 leaving;
    tlb_answer_t          tlb_ans;

    lane_fmt_if fmt_bus ();
    xlate_if    xl_bus ();

    assign in_allowin = !stage_valid || (ready && mem_allowin);
    assign leaving    = stage_valid && ready && mem_allowin;
    assign mem_valid  = stage_valid && ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (leaving && has_exc) begin
            stage_valid <= 1'b0;    // nothing follows an exception in
        end else if (exc_pending) begin
            stage_valid <= 1'b0;
        end else if (in_allowin) begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_pending <= 1'b0;
        end else if (leaving && has_exc) begin
            exc_pending <= 1'b1;
        end else if (ex_flush) begin
            exc_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            kind_r       <= in_kind;
            base_r       <= in_base;
            offset_r     <= in_offset;
            store_data_r <= in_store_data;
            dest_r       <= in_dest;
            pc_r         <= in_pc;
        end
    end

    assign addr_sum = base_r + {{(`LSU_XLEN-`LSU_OFFSET_BITS){offset_r[`LSU_OFFSET_BITS-1]}},
                                offset_r};
    // swl addresses the aligned word, lanes come from the low bits
    assign vaddr    = (kind_r == acc_swl) ? {addr_sum[`LSU_XLEN-1:2], 2'b00} : addr_sum;
    assign is_store = is_store_kind(kind_r);
    assign is_mem   = is_mem_kind(kind_r);

    assign tlb_ans = '{found: tlb_found, pfn: tlb_pfn, v: tlb_v, d: tlb_d};

    byte_lane_formatter byte_lane_formatter_inst (
        .kind        (kind_r),
        .byte_offset (addr_sum[1:0]),
        .store_data  (store_data_r),
        .fmt         (fmt_bus.source)
    );

    addr_translator addr_translator_inst (
        .vaddr        (vaddr),
        .is_store     (is_store),
        .is_mem       (is_mem),
        .asid         (asid),
        .tlb_vpn2     (tlb_vpn2),
        .tlb_odd_page (tlb_odd_page),
        .tlb_asid     (tlb_asid),
        .tlb_ans      (tlb_ans),
        .xl           (xl_bus.source)
    );

    mem_req_issue mem_req_issue_inst (
        .valid          (stage_valid),
        .mem_allowin    (mem_allowin),
        .is_store       (is_store),
        .is_mem         (is_mem),
        .vaddr          (vaddr),
        .fmt            (fmt_bus.sink),
        .xl             (xl_bus.sink),
        .dcache_valid   (dcache_valid),
        .dcache_op      (dcache_op),
        .dcache_uncache (dcache_uncache),
        .dcache_paddr   (dcache_paddr),
        .dcache_size    (dcache_size),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_wdata   (dcache_wdata),
        .dcache_addr_ok (dcache_addr_ok),
        .ready          (ready),
        .has_exc        (has_exc),
        .exc_code       (mem_exc_code),
        .badvaddr       (mem_badvaddr),
        .tlb_refill     (mem_tlb_refill)
    );

    assign mem_kind        = kind_r;
    assign mem_dest        = dest_r;
    assign mem_pc          = pc_r;
    assign mem_byte_offset = addr_sum[1:0];
    assign mem_has_exc     = has_exc;

endmodule

`default_nettype wire

// File: verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one access as offered on the decode side
typedef struct packed {
    access_kind_t kind;
    logic [31:0]  base;
    logic [15:0]  offset;
    logic [31:0]  store_data;
    logic [4:0]   dest;
    logic [31:0]  pc;
} access_t;

localparam pfn_t PFN_DELTA = 20'h0_5a3;   // responder pfn distance from vpn2

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// tlb responder, answer depends only on the low vpn2 bits
function automatic tlb_answer_t tlb_lookup(input vpn2_t vpn2);
    tlb_answer_t t;
    t.found = vpn2[1:0] != 2'b00;
    t.v     = vpn2[1:0] != 2'b01;
    t.d     = vpn2[2];
    t.pfn   = {1'b0, vpn2} + PFN_DELTA;
    return t;
endfunction

function automatic logic [31:0] effective_addr(input access_t a);
    return a.base + {{16{a.offset[15]}}, a.offset};
endfunction

function automatic logic [31:0] virtual_addr(input access_t a);
    logic [31:0] ea;
    ea = effective_addr(a);
    if (a.kind == acc_swl) begin
        ea[1:0] = 2'b00;    // swl goes to the aligned word
    end
    return ea;
endfunction

function automatic logic [1:0] lane_offset(input access_t a);
    logic [31:0] ea;
    ea = effective_addr(a);
    return ea[1:0];
endfunction

function automatic logic is_write(input access_kind_t k);
    return k inside {acc_sb, acc_sh, acc_sw, acc_swl, acc_swr};
endfunction

function automatic logic [3:0] lane_strobes(input access_kind_t k, input logic [1:0] off);
    case (k)
        acc_sb:  return 4'b0001 << off;
        acc_sh:  return off[1] ? 4'b1100 : 4'b0011;
        acc_sw:  return 4'b1111;
        acc_swl: return {off == 2'd3, off >= 2'd2, off != 2'd0, 1'b1};
        acc_swr: return {1'b1, off <= 2'd2, off <= 2'd1, off == 2'd0};
        default: return 4'b0000;
    endcase
endfunction

function automatic logic [31:0] lane_data(input access_kind_t k, input logic [1:0] off,
                                          input logic [31:0] d);
    case (k)
        acc_sb:  return {4{d[7:0]}};
        acc_sh:  return {2{d[15:0]}};
        acc_swl: return d >> {2'd3 - off, 3'b000};
        acc_swr: return d << {off, 3'b000};
        default: return d;
    endcase
endfunction

function automatic acc_size_t lane_size(input access_kind_t k, input logic [1:0] off);
    case (k)
        acc_lb, acc_lbu, acc_sb: return size_byte;
        acc_lh, acc_lhu, acc_sh: return size_half;
        acc_lwl, acc_swl:
            return (off == 2'd0) ? size_byte : ((off == 2'd1) ? size_half : size_word);
        acc_lwr, acc_swr:
            return (off == 2'd3) ? size_byte : ((off == 2'd2) ? size_half : size_word);
        default: return size_word;
    endcase
endfunction

function automatic logic misaligned(input access_kind_t k, input logic [1:0] off);
    case (k)
        acc_lh, acc_lhu, acc_sh: return off[0];
        acc_lw, acc_sw:          return off != 2'b00;
        default:                 return 1'b0;
    endcase
endfunction

// address error first, then tlb miss or invalid, then modified
function automatic exc_code_t expected_exc(input access_t a);
    logic [31:0] va;
    tlb_answer_t t;
    logic        st;
    va = virtual_addr(a);
    t  = tlb_lookup(va[31:13]);
    st = is_write(a.kind);
    if (misaligned(a.kind, lane_offset(a))) begin
        return st ? exc_ades : exc_adel;
    end
    if (va[31:30] == 2'b10) begin
        return exc_none;    // unmapped window never faults
    end
    if (!t.found || !t.v) begin
        return st ? exc_tlbs : exc_tlbl;
    end
    if (st && !t.d) begin
        return exc_mod;
    end
    return exc_none;
endfunction

function automatic logic refill_expected(input access_t a);
    logic [31:0] va;
    tlb_answer_t t;
    va = virtual_addr(a);
    t  = tlb_lookup(va[31:13]);
    return (va[31:30] != 2'b10) && !t.found;
endfunction

function automatic logic [31:0] expected_paddr(input access_t a);
    logic [31:0] va;
    tlb_answer_t t;
    va = virtual_addr(a);
    t  = tlb_lookup(va[31:13]);
    if (va[31:30] == 2'b10) begin
        return va & 32'h1fff_ffff;
    end
    return {t.pfn, va[11:0]};
endfunction

function automatic logic expected_uncache(input access_t a);
    logic [31:0] va;
    va = virtual_addr(a);
    return va[31:29] == 3'b101;
endfunction

`endif

// File: verification/tb_ex_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_mem_stage
    import mem_access_pkg::*;
    import mmu_pkg::*;
();

    localparam int NUM_ACCESSES = 300;
    localparam int CYCLE_LIMIT  = NUM_ACCESSES * 8 + 200;

    logic         clk;
    logic         reset;
    logic         in_valid;
    logic         in_allowin;
    access_kind_t in_kind;
    logic [31:0]  in_base;
    logic [15:0]  in_offset;
    logic [31:0]  in_store_data;
    logic [4:0]   in_dest;
    logic [31:0]  in_pc;
    logic         mem_allowin;
    logic         mem_valid;
    access_kind_t mem_kind;
    logic [4:0]   mem_dest;
    logic [31:0]  mem_pc;
    logic [1:0]   mem_byte_offset;
    logic         mem_has_exc;
    exc_code_t    mem_exc_code;
    logic [31:0]  mem_badvaddr;
    logic         mem_tlb_refill;
    logic         dcache_valid;
    logic         dcache_op;
    logic         dcache_uncache;
    paddr_t       dcache_paddr;
    acc_size_t    dcache_size;
    logic [3:0]   dcache_wstrb;
    logic [31:0]  dcache_wdata;
    logic         dcache_addr_ok;
    vpn2_t        tlb_vpn2;
    logic         tlb_odd_page;
    asid_t        tlb_asid;
    logic         tlb_found;
    pfn_t         tlb_pfn;
    logic         tlb_v;
    logic         tlb_d;
    asid_t        asid;
    logic         ex_flush;

    `include "tb_ref_model.svh"

    logic [31:0] rng_state;
    access_t     cur;           // access currently offered to decode
    access_t     expect_q[$];   // accepted and kept, oldest first
    access_t     head;
    logic        took;
    logic        pending;       // model of the exception-pending flag
    int          flush_wait;
    logic        req_wait;
    logic [71:0] held_req;
    logic [71:0] req_fields;
    logic        finished;
    int          errors;
    int          sent;
    int          dropped;
    int          delivered;
    int          cycles;

    assign req_fields = {dcache_op, dcache_uncache, dcache_paddr, dcache_size,
                         dcache_wstrb, dcache_wdata};

    ex_mem_stage ex_mem_stage_inst (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_kind         (in_kind),
        .in_base         (in_base),
        .in_offset       (in_offset),
        .in_store_data   (in_store_data),
        .in_dest         (in_dest),
        .in_pc           (in_pc),
        .mem_allowin     (mem_allowin),
        .mem_valid       (mem_valid),
        .mem_kind        (mem_kind),
        .mem_dest        (mem_dest),
        .mem_pc          (mem_pc),
        .mem_byte_offset (mem_byte_offset),
        .mem_has_exc     (mem_has_exc),
        .mem_exc_code    (mem_exc_code),
        .mem_badvaddr    (mem_badvaddr),
        .mem_tlb_refill  (mem_tlb_refill),
        .dcache_valid    (dcache_valid),
        .dcache_op       (dcache_op),
        .dcache_uncache  (dcache_uncache),
        .dcache_paddr    (dcache_paddr),
        .dcache_size     (dcache_size),
        .dcache_wstrb    (dcache_wstrb),
        .dcache_wdata    (dcache_wdata),
        .dcache_addr_ok  (dcache_addr_ok),
        .tlb_vpn2        (tlb_vpn2),
        .tlb_odd_page    (tlb_odd_page),
        .tlb_asid        (tlb_asid),
        .tlb_found       (tlb_found),
        .tlb_pfn         (tlb_pfn),
        .tlb_v           (tlb_v),
        .tlb_d           (tlb_d),
        .asid            (asid),
        .ex_flush        (ex_flush)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act, input logic [31:0] pc);
        assert (act == exp)
        else begin
            $display("ERR %s pc=%h: expected %h, actual %h", name, pc, exp, act);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond)
        else begin
            $display("error at cycle %0d: %s", cycles, what);
            errors++;
        end
    endtask

    // random kind, region and alignment; pc doubles as a sequence tag
    task automatic make_access(input int n);
        logic [31:0] r;
        logic [31:0] target;
        logic [3:0]  k;
        r = next_rand();
        k = 4'(r[7:0] % 8'd12);
        target = next_rand();
        case (r[9:8])
            2'd0:    target = {3'b100, target[28:0]};  // cached window
            2'd1:    target = {3'b101, target[28:0]};  // uncached window
            2'd2:    target = {1'b0, target[30:0]};
            default: target = {2'b11, target[29:0]};
        endcase
        if (r[11:10] != 2'b00) begin
            target[1:0] = 2'b00;    // mostly aligned
        end
        cur.kind       = access_kind_t'(k);
        cur.offset     = r[31:16];
        cur.base       = target - {{16{r[31]}}, r[31:16]};
        cur.store_data = next_rand();
        cur.dest       = 5'(n);
        cur.pc         = 32'hbfc0_0000 + (32'(n) << 2);
    endtask

    task automatic drive_inputs();
        tlb_answer_t t;
        logic [31:0] r;
        t = tlb_lookup(tlb_vpn2);   // for whatever sits in the stage now
        tlb_found = t.found;
        tlb_pfn   = t.pfn;
        tlb_v     = t.v;
        tlb_d     = t.d;
        r = next_rand();
        mem_allowin    = r[1:0] != 2'b00;
        dcache_addr_ok = r[2];
        asid           = r[15:8];
        ex_flush       = 1'b0;
        if (pending) begin
            if (flush_wait == 0) begin
                ex_flush = 1'b1;
            end else begin
                flush_wait--;
            end
        end
        if (took || !in_valid) begin
            in_valid = 1'b0;
            if (sent < NUM_ACCESSES && r[5:3] != 3'b000) begin
                make_access(sent);
                in_valid      = 1'b1;
                in_kind       = cur.kind;
                in_base       = cur.base;
                in_offset     = cur.offset;
                in_store_data = cur.store_data;
                in_dest       = cur.dest;
                in_pc         = cur.pc;
            end
        end
    endtask

    task automatic check_leaving(input access_t a);
        logic [1:0]  off;
        logic [31:0] va;
        exc_code_t   ec;
        off = lane_offset(a);
        va  = virtual_addr(a);
        ec  = expected_exc(a);
        delivered++;
        compare_field("order_pc", a.pc, mem_pc, a.pc);
        compare_field("kind", 32'(a.kind), 32'(mem_kind), a.pc);
        compare_field("dest", 32'(a.dest), 32'(mem_dest), a.pc);
        compare_field("byte_offset", 32'(off), 32'(mem_byte_offset), a.pc);
        compare_field("tlb_vpn2", 32'(va[31:13]), 32'(tlb_vpn2), a.pc);
        compare_field("tlb_odd_page", 32'(va[12]), 32'(tlb_odd_page), a.pc);
        compare_field("has_exc", 32'(ec != exc_none), 32'(mem_has_exc), a.pc);
        compare_field("tlb_refill", 32'(refill_expected(a)), 32'(mem_tlb_refill), a.pc);
        if (ec != exc_none) begin
            compare_field("exc_code", 32'(ec), 32'(mem_exc_code), a.pc);
            compare_field("badvaddr", virtual_addr(a), mem_badvaddr, a.pc);
            require(!dcache_valid, "excepting access raised dcache_valid");
        end else begin
            require(dcache_valid && dcache_addr_ok, "access left without cache acceptance");
            compare_field("dcache_op", 32'(is_write(a.kind)), 32'(dcache_op), a.pc);
            compare_field("dcache_paddr", expected_paddr(a), dcache_paddr, a.pc);
            compare_field("dcache_uncache", 32'(expected_uncache(a)), 32'(dcache_uncache),
                          a.pc);
            compare_field("dcache_size", 32'(lane_size(a.kind, off)), 32'(dcache_size), a.pc);
            compare_field("dcache_wstrb", 32'(lane_strobes(a.kind, off)), 32'(dcache_wstrb),
                          a.pc);
            if (is_write(a.kind)) begin
                compare_field("dcache_wdata", lane_data(a.kind, off, a.store_data),
                              dcache_wdata, a.pc);
            end
        end
    endtask

    // values here hold until the next rising edge
    task automatic sample_outputs();
        logic took_now;
        logic leave;
        logic leave_exc;
        took_now  = in_valid && in_allowin;
        leave     = mem_valid && mem_allowin;
        leave_exc = leave && mem_has_exc;
        require(!dcache_valid || mem_allowin, "dcache_valid high while mem_allowin is low");
        require(tlb_asid == asid, "tlb_asid does not follow asid");
        if (dcache_valid) begin
            require(mem_valid == dcache_addr_ok, "mem_valid does not match cache acceptance");
        end
        if (pending) begin
            require(!mem_valid && !dcache_valid, "memory activity before ex_flush");
        end
        if (req_wait && dcache_valid) begin
            require(req_fields == held_req, "request fields changed while waiting");
        end
        if (dcache_valid && !dcache_addr_ok) begin
            req_wait = 1'b1;
            held_req = req_fields;
        end
        if (leave) begin
            req_wait = 1'b0;
            if (expect_q.size() == 0) begin
                require(1'b0, "an access left with none outstanding");
            end else begin
                head = expect_q.pop_front();
                check_leaving(head);
            end
        end
        if (took_now) begin
            sent++;
            if (pending || leave_exc) begin
                dropped++;  // discarded behind an exception
            end else begin
                expect_q.push_back(cur);
            end
        end
        took = took_now;
        if (leave_exc) begin
            pending    = 1'b1;
            flush_wait = 32'(next_rand() & 32'd3);
        end else if (ex_flush) begin
            pending = 1'b0;
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_kind        = acc_lw;
        in_base        = '0;
        in_offset      = '0;
        in_store_data  = '0;
        in_dest        = '0;
        in_pc          = '0;
        mem_allowin    = 1'b0;
        dcache_addr_ok = 1'b0;
        tlb_found      = 1'b0;
        tlb_pfn        = '0;
        tlb_v          = 1'b0;
        tlb_d          = 1'b0;
        asid           = '0;
        ex_flush       = 1'b0;
        rng_state      = 32'ha8db_f6bc;
        took           = 1'b0;
        pending        = 1'b0;
        flush_wait     = 0;
        req_wait       = 1'b0;
        held_req       = '0;
        errors         = 0;
        sent           = 0;
        dropped        = 0;
        delivered      = 0;
        cycles         = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        finished = 1'b0;
        while (!finished && cycles < CYCLE_LIMIT) begin
            drive_inputs();
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
            #1;
            cycles++;
            finished = sent == NUM_ACCESSES && expect_q.size() == 0 && !in_valid;
        end
        if (!finished) begin
            $display("timeout: stopped after %0d cycles, %0d accesses sent, %0d outstanding",
                     cycles, sent, expect_q.size());
            errors++;
        end
        $display("accesses %0d, delivered %0d, dropped %0d, cycles %0d, errors %0d",
                 sent, delivered, dropped, cycles, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
+incdir+verification
hdl/mem_access_pkg.sv
hdl/mmu_pkg.sv
hdl/ex_ifs.sv
hdl/byte_lane_formatter.sv
hdl/addr_translator.sv
hdl/mem_req_issue.sv
hdl/ex_mem_stage.sv
verification/tb_ex_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the ex_mem_stage testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_ex_mem_stage

verilator --binary --timing --assert --timescale 1ns/10ps \
    -Mdir "$BUILD_DIR" -f sources.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
